/* tb.f */
hdl/tile_pkg.sv
hdl/tile_bus_decoder.sv
hdl/tile_ctrl_regs.sv
hdl/tile_sram.sv
hdl/tile_bootrom.sv
hdl/tile_top.sv
testbench/tile_assertions.sv
testbench/tb_tile_top.sv

/* testbench/tb_tile_top.sv */
// Drives the master port with single transfers only; every wait gives up after 20 cycles
module tb_tile_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 20;

  logic                        clk_i;
  logic                        reset_i;
  logic                        hsel_i;
  logic [tile_pkg::ADDR_W-1:0] haddr_i;
  logic [1:0]                  htrans_i;
  logic                        hwrite_i;
  logic [2:0]                  hsize_i;
  logic [tile_pkg::DATA_W-1:0] hwdata_i;
  logic [tile_pkg::DATA_W-1:0] hrdata_o;
  logic                        hready_o;
  logic                        hresp_o;

  int     mismatch_count;
  int     timeout_count;
  integer seed;

  // Expected SRAM contents for the random test
  logic [tile_pkg::DATA_W-1:0] sram_model [tile_pkg::SRAM_WORDS];

  tile_top tile_top_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .hsel_i  (hsel_i),
    .haddr_i (haddr_i),
    .htrans_i(htrans_i),
    .hwrite_i(hwrite_i),
    .hsize_i (hsize_i),
    .hwdata_i(hwdata_i),
    .hrdata_o(hrdata_o),
    .hready_o(hready_o),
    .hresp_o (hresp_o)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////

  task automatic drive_addr(input logic [tile_pkg::ADDR_W-1:0] addr, input logic write,
                            input logic [2:0] size);
    hsel_i   = 1'b1;
    haddr_i  = addr;
    htrans_i = tile_pkg::HTRANS_NONSEQ;
    hwrite_i = write;
    hsize_i  = size;
  endtask

  task automatic drive_idle();
    hsel_i   = 1'b0;
    htrans_i = tile_pkg::HTRANS_IDLE;
    hwrite_i = 1'b0;
  endtask

  // Address phase is taken on the edge where hready_o is high
  task automatic wait_accept();
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < TIMEOUT) begin
      @(negedge clk_i);
      done = hready_o;
      @(posedge clk_i);
      cycles++;
    end
    #1;
    if (!done) begin
      timeout_count++;
      $display("Timeout: address phase never accepted, hready_o stayed low");
    end
  endtask

  // Last data phase cycle carries the read data and the response
  task automatic collect_response(output logic [tile_pkg::DATA_W-1:0] data, output logic resp);
    int   cycles;
    bit   done;
    logic stalled;
    cycles  = 0;
    done    = 1'b0;
    stalled = 1'b0;
    data    = 'x;
    resp    = 1'bx;
    while (!done && cycles < TIMEOUT) begin
      @(negedge clk_i);
      if (hready_o) begin
        data = hrdata_o;
        resp = hresp_o;
        done = 1'b1;
      end else begin
        stalled = 1'b1;
      end
      @(posedge clk_i);
      cycles++;
    end
    #1;
    if (!done) begin
      timeout_count++;
      $display("Timeout: data phase never completed, hready_o stayed low");
    end else begin
      // An ERROR stalls once before it completes, an OKAY never does
      check_resp("hready_o stall", stalled, resp);
    end
  endtask

  task automatic ahb_write(input logic [tile_pkg::ADDR_W-1:0] addr, input logic [2:0] size,
                           input logic [tile_pkg::DATA_W-1:0] data, output logic resp);
    logic [tile_pkg::DATA_W-1:0] unused;
    drive_addr(addr, 1'b1, size);
    wait_accept();
    drive_idle();
    hwdata_i = data;
    collect_response(unused, resp);
  endtask

  task automatic ahb_read(input logic [tile_pkg::ADDR_W-1:0] addr,
                          output logic [tile_pkg::DATA_W-1:0] data, output logic resp);
    drive_addr(addr, 1'b0, tile_pkg::HSIZE_WORD);
    wait_accept();
    drive_idle();
    collect_response(data, resp);
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input logic [tile_pkg::DATA_W-1:0] got,
                            input logic [tile_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic logic [tile_pkg::ADDR_W-1:0] sram_addr(
    input logic [tile_pkg::SRAM_IDX_W-1:0] idx);
    return {tile_pkg::REGION_SRAM, 18'h0, idx, 2'b00};
  endfunction

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_sram_words();
    logic [tile_pkg::SRAM_IDX_W-1:0] idx [8];
    logic [tile_pkg::DATA_W-1:0]     data;
    logic                            resp;
    for (int i = 0; i < 8; i++) begin
      idx[i] = $random(seed);
      data   = $random(seed);
      sram_model[idx[i]] = data;
      ahb_write(sram_addr(idx[i]), tile_pkg::HSIZE_WORD, data, resp);
      check_resp("hresp_o sram write", resp, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      ahb_read(sram_addr(idx[i]), data, resp);
      check_data("hrdata_o sram word", data, sram_model[idx[i]]);
      check_resp("hresp_o sram read", resp, 1'b0);
    end
    // Byte into lane 1, then halfword into lanes 2 and 3
    ahb_write(32'h0000_000C, tile_pkg::HSIZE_WORD, 32'h1122_3344, resp);
    ahb_write(32'h0000_000D, tile_pkg::HSIZE_BYTE, 32'h0000_AA00, resp);
    ahb_read(32'h0000_000C, data, resp);
    check_data("hrdata_o sram byte merge", data, 32'h1122_AA44);
    ahb_write(32'h0000_000E, tile_pkg::HSIZE_HALF, 32'hBEEF_0000, resp);
    ahb_read(32'h0000_000C, data, resp);
    check_data("hrdata_o sram half merge", data, 32'hBEEF_AA44);
  endtask

  task automatic test_boot_rom();
    logic [tile_pkg::DATA_W-1:0] data;
    logic                        resp;
    for (int i = 0; i < tile_pkg::ROM_WORDS; i++) begin
      ahb_read(32'hF000_0000 + 4 * i, data, resp);
      check_data("hrdata_o rom", data, tile_pkg::BOOT_IMAGE[i]);
      check_resp("hresp_o rom read", resp, 1'b0);
    end
    ahb_write(32'hF000_0010, tile_pkg::HSIZE_WORD, 32'h1234_5678, resp);
    check_resp("hresp_o rom write", resp, 1'b1);
    ahb_read(32'hF000_0010, data, resp);
    check_data("hrdata_o rom after write", data, tile_pkg::BOOT_IMAGE[4]);
  endtask

  task automatic test_ctrl_regs();
    logic [tile_pkg::DATA_W-1:0] data;
    logic [tile_pkg::DATA_W-1:0] value;
    logic                        resp;
    ahb_read(32'hE000_0000 + tile_pkg::REG_SLAVE_EN, data, resp);
    check_data("hrdata_o slave_en reset", data, 32'(tile_pkg::SLAVE_EN_RESET));
    value = $random(seed);
    ahb_write(32'hE000_0000 + tile_pkg::REG_SCRATCH, tile_pkg::HSIZE_WORD, value, resp);
    check_resp("hresp_o scratch write", resp, 1'b0);
    ahb_read(32'hE000_0000 + tile_pkg::REG_SCRATCH, data, resp);
    check_data("hrdata_o scratch", data, value);
    ahb_read(32'hE000_0000 + tile_pkg::REG_TILE_ID, data, resp);
    check_data("hrdata_o tile_id", data, tile_pkg::TILE_ID);
    ahb_write(32'hE000_0000 + tile_pkg::REG_TILE_ID, tile_pkg::HSIZE_WORD, ~value, resp);
    ahb_read(32'hE000_0000 + tile_pkg::REG_TILE_ID, data, resp);
    check_data("hrdata_o tile_id after write", data, tile_pkg::TILE_ID);
  endtask

  task automatic test_slave_enables();
    logic [tile_pkg::ADDR_W-1:0] en_addr;
    logic [tile_pkg::DATA_W-1:0] kept;
    logic [tile_pkg::DATA_W-1:0] data;
    logic                        resp;
    en_addr = 32'hE000_0000 + tile_pkg::REG_SLAVE_EN;
    kept    = $random(seed);
    ahb_write(sram_addr(8'h20), tile_pkg::HSIZE_WORD, kept, resp);
    // SRAM off, ROM on
    ahb_write(en_addr, tile_pkg::HSIZE_WORD, 32'(1) << tile_pkg::EN_ROM_BIT, resp);
    ahb_read(sram_addr(8'h20), data, resp);
    check_resp("hresp_o sram read disabled", resp, 1'b1);
    ahb_write(sram_addr(8'h20), tile_pkg::HSIZE_WORD, ~kept, resp);
    check_resp("hresp_o sram write disabled", resp, 1'b1);
    ahb_read(32'hF000_0000, data, resp);
    check_data("hrdata_o rom with sram off", data, tile_pkg::BOOT_IMAGE[0]);
    check_resp("hresp_o rom with sram off", resp, 1'b0);
    ahb_write(en_addr, tile_pkg::HSIZE_WORD, 32'(tile_pkg::SLAVE_EN_RESET), resp);
    ahb_read(sram_addr(8'h20), data, resp);
    check_data("hrdata_o sram re-enabled", data, kept);
    check_resp("hresp_o sram re-enabled", resp, 1'b0);
    // ROM off, SRAM on
    ahb_write(en_addr, tile_pkg::HSIZE_WORD, 32'(1) << tile_pkg::EN_SRAM_BIT, resp);
    ahb_read(32'hF000_0014, data, resp);
    check_resp("hresp_o rom read disabled", resp, 1'b1);
    ahb_read(sram_addr(8'h20), data, resp);
    check_data("hrdata_o sram with rom off", data, kept);
    check_resp("hresp_o sram with rom off", resp, 1'b0);
    ahb_write(en_addr, tile_pkg::HSIZE_WORD, 32'(tile_pkg::SLAVE_EN_RESET), resp);
    ahb_read(32'hF000_0014, data, resp);
    check_data("hrdata_o rom re-enabled", data, tile_pkg::BOOT_IMAGE[5]);
    check_resp("hresp_o rom re-enabled", resp, 1'b0);
  endtask

  task automatic test_unmapped();
    logic [tile_pkg::DATA_W-1:0] data;
    logic                        resp;
    ahb_read(32'h5000_0040, data, resp);
    check_resp("hresp_o unmapped read", resp, 1'b1);
    ahb_write(32'h5000_0040, tile_pkg::HSIZE_WORD, 32'hCAFE_F00D, resp);
    check_resp("hresp_o unmapped write", resp, 1'b1);
  endtask

  // Read address phase overlaps the write data phase
  task automatic test_pipelined();
    logic [tile_pkg::SRAM_IDX_W-1:0] idx;
    logic [tile_pkg::DATA_W-1:0]     value;
    logic [tile_pkg::DATA_W-1:0]     data;
    logic                            wresp;
    logic                            rresp;
    idx   = $random(seed);
    value = $random(seed);
    ahb_write(sram_addr(idx), tile_pkg::HSIZE_WORD, ~value, wresp);
    drive_addr(sram_addr(idx), 1'b1, tile_pkg::HSIZE_WORD);
    wait_accept();
    hwdata_i = value;
    drive_addr(sram_addr(idx), 1'b0, tile_pkg::HSIZE_WORD);
    collect_response(data, wresp);
    drive_idle();
    collect_response(data, rresp);
    check_resp("hresp_o pipelined write", wresp, 1'b0);
    check_resp("hresp_o pipelined read", rresp, 1'b0);
    check_data("hrdata_o pipelined read", data, value);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    hsel_i         = 1'b0;
    haddr_i        = '0;
    htrans_i       = tile_pkg::HTRANS_IDLE;
    hwrite_i       = 1'b0;
    hsize_i        = tile_pkg::HSIZE_WORD;
    hwdata_i       = '0;
    mismatch_count = 0;
    timeout_count  = 0;
    seed           = 69;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    test_ctrl_regs();
    test_sram_words();
    test_boot_rom();
    test_slave_enables();
    test_unmapped();
    test_pipelined();

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* testbench/tile_assertions.sv */
// Bound to tile_top; checks the AHB-Lite wait and error response rules only, not data values
module tile_assertions (
  input logic                 clk_i,
  input logic                 reset_i,
  input logic                 hready_i,
  input logic                 hresp_i,
  input tile_pkg::slave_sel_t owner_i
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // Response sequence
  ////////////////////////////////////////

  // Zero-wait slaves, so only an error stalls, and only for one cycle
  assert property (@(posedge clk_i) disable iff (reset_i) !hready_i |=> hready_i)
    else $error("hready_o low for two cycles in a row");

  assert property (@(posedge clk_i) disable iff (reset_i) !hready_i |-> hresp_i)
    else $error("hready_o low without an error response");

  // Second error cycle
  assert property (@(posedge clk_i) disable iff (reset_i) !hready_i |=> (hready_i && hresp_i))
    else $error("first error cycle not followed by the second one");

  // Idle bus with no data phase owner once reset ends
  assert property (@(posedge clk_i)
                   $fell(reset_i) |-> (hready_i && !hresp_i && (owner_i == tile_pkg::SEL_NONE)))
    else $error("bus not idle with an OKAY response after reset");

endmodule

bind tile_top tile_assertions tile_assertions_inst (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .hready_i(hready_o),
  .hresp_i (hresp_o),
  .owner_i (u_decoder.owner_q)
);

/* hdl/tile_top.sv */
// Single AHB-Lite master port with no bursts and no bus hold; only regions 0x0, 0xE and 0xF map
module tile_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        hsel_i,
  input  logic [tile_pkg::ADDR_W-1:0] haddr_i,
  input  logic [1:0]                  htrans_i,
  input  logic                        hwrite_i,
  input  logic [2:0]                  hsize_i,
  input  logic [tile_pkg::DATA_W-1:0] hwdata_i,
  output logic [tile_pkg::DATA_W-1:0] hrdata_o,
  output logic                        hready_o,
  output logic                        hresp_o
);

  logic                        sram_sel;
  logic                        rom_sel;
  logic                        ctrl_sel;
  logic [tile_pkg::DATA_W-1:0] sram_rdata;
  logic [tile_pkg::DATA_W-1:0] rom_rdata;
  logic [tile_pkg::DATA_W-1:0] ctrl_rdata;
  logic                        sram_en;
  logic                        rom_en;

  ////////////////////////////////////////
  // Decoder and steering
  ////////////////////////////////////////

  tile_bus_decoder u_decoder (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .hsel_i      (hsel_i),
    .htrans_i    (htrans_i),
    .hwrite_i    (hwrite_i),
    .haddr_i     (haddr_i),
    .sram_en_i   (sram_en),
    .rom_en_i    (rom_en),
    .sram_rdata_i(sram_rdata),
    .rom_rdata_i (rom_rdata),
    .ctrl_rdata_i(ctrl_rdata),
    .sram_sel_o  (sram_sel),
    .rom_sel_o   (rom_sel),
    .ctrl_sel_o  (ctrl_sel),
    .hrdata_o    (hrdata_o),
    .hready_o    (hready_o),
    .hresp_o     (hresp_o)
  );

  tile_ctrl_regs u_ctrl_regs (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .sel_i    (ctrl_sel),
    .hwrite_i (hwrite_i),
    .haddr_i  (haddr_i),
    .hwdata_i (hwdata_i),
    .rdata_o  (ctrl_rdata),
    .sram_en_o(sram_en),
    .rom_en_o (rom_en)
  );

  ////////////////////////////////////////
  // Local slaves
  ////////////////////////////////////////

  tile_sram u_sram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .sel_i   (sram_sel),
    .hwrite_i(hwrite_i),
    .hsize_i (hsize_i),
    .haddr_i (haddr_i),
    .hwdata_i(hwdata_i),
    .rdata_o (sram_rdata)
  );

  tile_bootrom u_bootrom (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .sel_i  (rom_sel),
    .haddr_i(haddr_i),
    .rdata_o(rom_rdata)
  );

endmodule

/* hdl/tile_bootrom.sv */
// Reads return the whole word whatever hsize is; address bits above the image size wrap
module tile_bootrom (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        sel_i,
  input  tile_pkg::tile_addr_t        haddr_i,
  output logic [tile_pkg::DATA_W-1:0] rdata_o
);

  localparam int ROM_IDX_W = $clog2(tile_pkg::ROM_WORDS);

  logic [ROM_IDX_W-1:0] idx_q;

  // Word index modulo the image depth
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      idx_q <= '0;
    end else if (sel_i) begin
      idx_q <= haddr_i.word_view.idx[ROM_IDX_W-1:0];
    end
  end

  // Fixed image out in the data phase
  assign rdata_o = tile_pkg::BOOT_IMAGE[idx_q];

endmodule

/* hdl/tile_sram.sv */
// Memory contents are undefined after power up and sizes above a word write nothing
module tile_sram (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        sel_i,
  input  logic                        hwrite_i,
  input  logic [2:0]                  hsize_i,
  input  tile_pkg::tile_addr_t        haddr_i,
  input  logic [tile_pkg::DATA_W-1:0] hwdata_i,
  output logic [tile_pkg::DATA_W-1:0] rdata_o
);

  localparam int LANES = tile_pkg::DATA_W / 8;

  logic [tile_pkg::DATA_W-1:0]   mem [tile_pkg::SRAM_WORDS];
  logic [tile_pkg::SRAM_IDX_W-1:0] idx_q;
  logic [1:0]                    lane_q;
  logic [2:0]                    size_q;
  logic                          wr_q;
  logic [LANES-1:0]              be;

  ////////////////////////////////////////
  // Address phase capture
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      idx_q  <= haddr_i.word_view.idx;
      lane_q <= haddr_i.word_view.lane;
      size_q <= hsize_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= sel_i && hwrite_i;
    end
  end

  ////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////

  // Byte enables from size and lane
  always_comb begin
    case (size_q)
      tile_pkg::HSIZE_BYTE: be = 4'b0001 << lane_q;
      tile_pkg::HSIZE_HALF: be = lane_q[1] ? 4'b1100 : 4'b0011;
      tile_pkg::HSIZE_WORD: be = 4'b1111;
      default:              be = 4'b0000;
    endcase
  end

  // Only the enabled bytes land
  always_ff @(posedge clk_i) begin
    if (wr_q) begin
      for (int b = 0; b < LANES; b++) begin
        if (be[b]) begin
          mem[idx_q][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rdata_o = mem[idx_q];

endmodule

/* hdl/tile_ctrl_regs.sv */
// Register accesses are taken as full words and hsize is ignored; offsets alias every 1 KB
module tile_ctrl_regs (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        sel_i,
  input  logic                        hwrite_i,
  input  tile_pkg::tile_addr_t        haddr_i,
  input  logic [tile_pkg::DATA_W-1:0] hwdata_i,
  output logic [tile_pkg::DATA_W-1:0] rdata_o,
  output logic                        sram_en_o,
  output logic                        rom_en_o
);

  logic [tile_pkg::SRAM_IDX_W+1:0] off_q;
  logic                            wr_q;
  logic [1:0]                      slave_en_q;
  logic [tile_pkg::DATA_W-1:0]     scratch_q;

  // Byte offset of the selected phase
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      off_q <= {haddr_i.word_view.idx, haddr_i.word_view.lane};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_q       <= 1'b0;
      slave_en_q <= tile_pkg::SLAVE_EN_RESET;
    end else begin
      wr_q <= sel_i && hwrite_i;
      if (wr_q && (off_q == tile_pkg::REG_SLAVE_EN)) begin
        slave_en_q[tile_pkg::EN_SRAM_BIT] <= hwdata_i[tile_pkg::EN_SRAM_BIT];
        slave_en_q[tile_pkg::EN_ROM_BIT]  <= hwdata_i[tile_pkg::EN_ROM_BIT];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_q && (off_q == tile_pkg::REG_SCRATCH)) begin
      scratch_q <= hwdata_i;
    end
  end

  // Read back at the latched offset
  always_comb begin
    rdata_o = '0;
    case (off_q)
      tile_pkg::REG_SLAVE_EN: begin
        rdata_o[tile_pkg::EN_SRAM_BIT] = slave_en_q[tile_pkg::EN_SRAM_BIT];
        rdata_o[tile_pkg::EN_ROM_BIT]  = slave_en_q[tile_pkg::EN_ROM_BIT];
      end
      tile_pkg::REG_SCRATCH: rdata_o = scratch_q;
      tile_pkg::REG_TILE_ID: rdata_o = tile_pkg::TILE_ID;
      default:               rdata_o = '0;
    endcase
  end

  // Enables steer the decoder
  assign sram_en_o = slave_en_q[tile_pkg::EN_SRAM_BIT];
  assign rom_en_o  = slave_en_q[tile_pkg::EN_ROM_BIT];

endmodule

/* hdl/tile_bus_decoder.sv */
// Assumes one master issuing single IDLE or NONSEQ transfers to zero-wait slaves only
module tile_bus_decoder (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        hsel_i,
  input  logic [1:0]                  htrans_i,
  input  logic                        hwrite_i,
  input  tile_pkg::tile_addr_t        haddr_i,
  input  logic                        sram_en_i,
  input  logic                        rom_en_i,
  input  logic [tile_pkg::DATA_W-1:0] sram_rdata_i,
  input  logic [tile_pkg::DATA_W-1:0] rom_rdata_i,
  input  logic [tile_pkg::DATA_W-1:0] ctrl_rdata_i,
  output logic                        sram_sel_o,
  output logic                        rom_sel_o,
  output logic                        ctrl_sel_o,
  output logic [tile_pkg::DATA_W-1:0] hrdata_o,
  output logic                        hready_o,
  output logic                        hresp_o
);

  logic                 accept;
  logic                 err_hit;
  tile_pkg::slave_sel_t owner_d;
  tile_pkg::slave_sel_t owner_q;
  // First and second cycle of the error response
  logic                 err1_q;
  logic                 err2_q;

  assign hready_o = ~err1_q;
  assign hresp_o  = err1_q | err2_q;

  // Address phase is taken only while the bus is ready
  assign accept = hsel_i && (htrans_i == tile_pkg::HTRANS_NONSEQ) && hready_o;

  ////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////

  always_comb begin
    owner_d = tile_pkg::SEL_NONE;
    err_hit = 1'b0;
    if (accept) begin
      case (haddr_i.region_view.region)
        tile_pkg::REGION_SRAM: begin
          if (sram_en_i) owner_d = tile_pkg::SEL_SRAM;
          else err_hit = 1'b1;
        end
        tile_pkg::REGION_ROM: begin
          // ROM never takes writes
          if (rom_en_i && !hwrite_i) owner_d = tile_pkg::SEL_ROM;
          else err_hit = 1'b1;
        end
        tile_pkg::REGION_CTRL: owner_d = tile_pkg::SEL_CTRL;
        default: err_hit = 1'b1;
      endcase
    end
  end

  assign sram_sel_o = (owner_d == tile_pkg::SEL_SRAM);
  assign rom_sel_o  = (owner_d == tile_pkg::SEL_ROM);
  assign ctrl_sel_o = (owner_d == tile_pkg::SEL_CTRL);

  ////////////////////////////////////////
  // Data phase owner and error sequence
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner_q <= tile_pkg::SEL_NONE;
      err1_q  <= 1'b0;
      err2_q  <= 1'b0;
    end else begin
      owner_q <= owner_d;
      err1_q  <= err_hit;
      err2_q  <= err1_q;
    end
  end

  // Read data from the current owner
  always_comb begin
    case (owner_q)
      tile_pkg::SEL_SRAM: hrdata_o = sram_rdata_i;
      tile_pkg::SEL_ROM:  hrdata_o = rom_rdata_i;
      tile_pkg::SEL_CTRL: hrdata_o = ctrl_rdata_i;
      default:            hrdata_o = '0;
    endcase
  end

endmodule

/* hdl/tile_pkg.sv */
// Memory map and bus encodings of the tile; control registers alias every 1 KB in their region
package tile_pkg;

  ////////////////////////////////////////
  // Bus widths and encodings
  ////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  ////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////

  localparam logic [3:0] REGION_SRAM = 4'h0;
  localparam logic [3:0] REGION_CTRL = 4'hE;
  localparam logic [3:0] REGION_ROM  = 4'hF;

  localparam int SRAM_WORDS = 256;
  localparam int SRAM_IDX_W = 8;
  localparam int ROM_WORDS  = 16;

  // Boot image, a short startup loop
  localparam logic [DATA_W-1:0] BOOT_IMAGE [ROM_WORDS] = '{
    32'h0000_0093, 32'h0000_0113, 32'h0000_0193, 32'h0000_0213,
    32'h0e00_02b7, 32'h0002_a303, 32'h0042_a383, 32'h0063_8433,
    32'h0000_04b7, 32'h0084_a023, 32'h0044_a503, 32'h00a4_0463,
    32'hfe00_0ee3, 32'h0010_0073, 32'h0000_006f, 32'hdead_c0de
  };

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////

  // Byte offsets inside the control region
  localparam logic [SRAM_IDX_W+1:0] REG_SLAVE_EN = 10'h000;
  localparam logic [SRAM_IDX_W+1:0] REG_SCRATCH  = 10'h004;
  localparam logic [SRAM_IDX_W+1:0] REG_TILE_ID  = 10'h008;

  localparam logic [DATA_W-1:0] TILE_ID = 32'h7113_0001;

  localparam int EN_SRAM_BIT = 0;
  localparam int EN_ROM_BIT  = 1;

  // Both slaves answer after reset
  localparam logic [1:0] SLAVE_EN_RESET = 2'b11;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef union packed {
    struct packed {
      logic [3:0]  region;
      logic [27:0] offset;
    } region_view;
    struct packed {
      logic [ADDR_W-SRAM_IDX_W-3:0] upper;
      logic [SRAM_IDX_W-1:0]        idx;
      logic [1:0]                   lane;
    } word_view;
  } tile_addr_t;

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_SRAM,
    SEL_ROM,
    SEL_CTRL
  } slave_sel_t;

endpackage
